/* hdl/tetris_board_pkg.sv */
package tetris_board_pkg;

    // ==================================================
    // Board geometry
    // ==================================================

    // Row 0 is the top row, row 19 the floor
    localparam int BOARD_ROWS = 20;
    localparam int BOARD_COLS = 10;

    // One board row, bit c is column c
    typedef logic [BOARD_COLS-1:0] board_row_t;
    typedef board_row_t [BOARD_ROWS-1:0] board_t;

    // Piece box corner coordinates
    typedef logic [4:0] row_idx_t;
    typedef logic [3:0] col_idx_t;

    // Count of cleared lines
    typedef logic [7:0] score_t;

    // ==================================================
    // Game FSM states
    // ==================================================

    typedef enum logic [2:0] {
        INIT,
        SPAWN,
        FALLING,
        ROTATE,
        STUCK,
        LANDED,
        EVAL,
        GAMEOVER
    } game_state_t;

endpackage

/* hdl/tetris_piece_pkg.sv */
package tetris_piece_pkg;

    // Shape plus orientation in one code
    typedef logic [4:0] piece_code_t;

    // Base shape picked by the host, 0 to 6
    typedef logic [2:0] piece_sel_t;

    // 4x4 box, bit [r][c] is box row r, box column c
    typedef logic [3:0][3:0] pattern_t;

    // ==================================================
    // Piece codes
    // ==================================================

    // Base orientations, equal to the select values
    localparam piece_code_t PIECE_I_VERT = 5'd0;
    localparam piece_code_t PIECE_O      = 5'd1;
    localparam piece_code_t PIECE_S_H    = 5'd2;
    localparam piece_code_t PIECE_Z_H    = 5'd3;
    localparam piece_code_t PIECE_J_0    = 5'd4;
    localparam piece_code_t PIECE_L_0    = 5'd5;
    localparam piece_code_t PIECE_T_0    = 5'd6;

    // Rotated orientations
    localparam piece_code_t PIECE_I_HORZ = 5'd7;
    localparam piece_code_t PIECE_Z_V    = 5'd8;
    localparam piece_code_t PIECE_S_V    = 5'd9;
    localparam piece_code_t PIECE_J_90   = 5'd10;
    localparam piece_code_t PIECE_J_180  = 5'd11;
    localparam piece_code_t PIECE_J_270  = 5'd12;
    localparam piece_code_t PIECE_L_90   = 5'd13;
    localparam piece_code_t PIECE_L_180  = 5'd14;
    localparam piece_code_t PIECE_L_270  = 5'd15;
    localparam piece_code_t PIECE_T_270  = 5'd16;
    localparam piece_code_t PIECE_T_180  = 5'd17;
    localparam piece_code_t PIECE_T_90   = 5'd18;

    // Spawn point of the box corner
    localparam tetris_board_pkg::row_idx_t SPAWN_ROW = 5'd0;
    localparam tetris_board_pkg::col_idx_t SPAWN_COL = 4'd3;

endpackage

/* hdl/tetris_input_sync.sv */
`timescale 1ns/1ps

module tetris_input_sync (
    input  logic clk,
    input  logic reset,
    input  logic left_i,
    input  logic right_i,
    input  logic rot_cw_i,
    input  logic rot_ccw_i,
    input  logic drop_tick_i,
    output logic left_o,
    output logic right_o,
    output logic rot_cw_o,
    output logic rot_ccw_o,
    output logic drop_o
);

    // All five inputs share one synchronizer vector
    logic [4:0] raw;
    logic [4:0] meta_q;
    logic [4:0] sync_q;
    logic [4:0] prev_q;
    logic [4:0] rise;

    assign raw = {drop_tick_i, rot_ccw_i, rot_cw_i, right_i, left_i};

    // Two flops, then one more for edge detect
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            meta_q <= '0;
            sync_q <= '0;
            prev_q <= '0;
        end else begin
            meta_q <= raw;
            sync_q <= meta_q;
            prev_q <= sync_q;
        end
    end

    // One-cycle strobe per rising edge
    assign rise = sync_q & ~prev_q;

    assign left_o    = rise[0];
    assign right_o   = rise[1];
    assign rot_cw_o  = rise[2];
    assign rot_ccw_o = rise[3];
    assign drop_o    = rise[4];

endmodule

/* hdl/tetris_piece_engine.sv */
`timescale 1ns/1ps

module tetris_piece_engine (
    input  logic                          clk,
    input  logic                          reset,
    input  tetris_board_pkg::game_state_t state_i,
    input  tetris_piece_pkg::piece_sel_t  piece_sel_i,
    input  logic                          left_i,
    input  logic                          right_i,
    input  logic                          rot_cw_i,
    input  logic                          rot_ccw_i,
    input  logic                          drop_i,
    input  tetris_board_pkg::board_t      stored_i,
    output tetris_piece_pkg::piece_code_t piece_code_o,
    output tetris_board_pkg::board_t      falling_o,
    output logic                          coll_bottom_o,
    output logic                          coll_left_o,
    output logic                          coll_right_o
);

    import tetris_board_pkg::*;
    import tetris_piece_pkg::*;

    // Falling piece state
    row_idx_t    row_q;
    col_idx_t    col_q;
    piece_code_t code_q;
    logic        rot_ccw_q;

    piece_code_t next_code;
    pattern_t    pattern;
    col_idx_t    nudge;

    assign piece_code_o = code_q;

    // Horizontal I needs two columns of room
    assign nudge = (code_q == PIECE_I_HORZ) ? 4'd2 : 4'd1;

    // ==================================================
    // Position, code and rotate direction
    // ==================================================

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            row_q     <= SPAWN_ROW;
            col_q     <= SPAWN_COL;
            code_q    <= PIECE_I_VERT;
            rot_ccw_q <= 1'b0;
        end else begin
            case (state_i)
                SPAWN: begin
                    row_q  <= SPAWN_ROW;
                    col_q  <= SPAWN_COL;
                    code_q <= {2'b00, piece_sel_i};
                end
                FALLING: begin
                    // Gravity, held while resting
                    if (drop_i && !coll_bottom_o) begin
                        row_q <= row_q + 5'd1;
                    end
                    // Left has priority over right
                    if (left_i && !coll_left_o) begin
                        col_q <= col_q - 4'd1;
                    end else if (right_i && !coll_right_o) begin
                        col_q <= col_q + 4'd1;
                    end
                    // Remember which way to turn in ROTATE
                    if (rot_cw_i || rot_ccw_i) begin
                        rot_ccw_q <= rot_ccw_i & ~rot_cw_i;
                    end
                end
                ROTATE: begin
                    code_q <= next_code;
                    // Push away from whatever the piece touches
                    if (coll_left_o) begin
                        col_q <= col_q + nudge;
                    end else if (coll_right_o) begin
                        col_q <= col_q - nudge;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // ==================================================
    // Rotation table
    // ==================================================

    // Two-state shapes flip either way, O and unknown codes stay
    always_comb begin
        case (code_q)
            PIECE_I_VERT: next_code = PIECE_I_HORZ;
            PIECE_I_HORZ: next_code = PIECE_I_VERT;
            PIECE_S_H:    next_code = PIECE_S_V;
            PIECE_S_V:    next_code = PIECE_S_H;
            PIECE_Z_H:    next_code = PIECE_Z_V;
            PIECE_Z_V:    next_code = PIECE_Z_H;
            PIECE_J_0:    next_code = rot_ccw_q ? PIECE_J_270 : PIECE_J_90;
            PIECE_J_90:   next_code = rot_ccw_q ? PIECE_J_0   : PIECE_J_180;
            PIECE_J_180:  next_code = rot_ccw_q ? PIECE_J_90  : PIECE_J_270;
            PIECE_J_270:  next_code = rot_ccw_q ? PIECE_J_180 : PIECE_J_0;
            PIECE_L_0:    next_code = rot_ccw_q ? PIECE_L_270 : PIECE_L_90;
            PIECE_L_90:   next_code = rot_ccw_q ? PIECE_L_0   : PIECE_L_180;
            PIECE_L_180:  next_code = rot_ccw_q ? PIECE_L_90  : PIECE_L_270;
            PIECE_L_270:  next_code = rot_ccw_q ? PIECE_L_180 : PIECE_L_0;
            PIECE_T_0:    next_code = rot_ccw_q ? PIECE_T_270 : PIECE_T_90;
            PIECE_T_90:   next_code = rot_ccw_q ? PIECE_T_0   : PIECE_T_180;
            PIECE_T_180:  next_code = rot_ccw_q ? PIECE_T_90  : PIECE_T_270;
            PIECE_T_270:  next_code = rot_ccw_q ? PIECE_T_180 : PIECE_T_0;
            default:      next_code = code_q;
        endcase
    end

    // ==================================================
    // Pattern lookup
    // ==================================================

    // Rows listed 3 down to 0, bit 0 of each row is the left column
    always_comb begin
        case (code_q)
            PIECE_I_VERT: pattern = {4'b0001, 4'b0001, 4'b0001, 4'b0001};
            PIECE_I_HORZ: pattern = {4'b0000, 4'b0000, 4'b0000, 4'b1111};
            PIECE_O:      pattern = {4'b0000, 4'b0000, 4'b0011, 4'b0011};
            PIECE_S_H:    pattern = {4'b0000, 4'b0000, 4'b0011, 4'b0110};
            PIECE_S_V:    pattern = {4'b0000, 4'b0010, 4'b0011, 4'b0001};
            PIECE_Z_H:    pattern = {4'b0000, 4'b0000, 4'b0110, 4'b0011};
            PIECE_Z_V:    pattern = {4'b0000, 4'b0001, 4'b0011, 4'b0010};
            PIECE_J_0:    pattern = {4'b0000, 4'b0000, 4'b0111, 4'b0001};
            PIECE_J_90:   pattern = {4'b0000, 4'b0001, 4'b0001, 4'b0011};
            PIECE_J_180:  pattern = {4'b0000, 4'b0000, 4'b0100, 4'b0111};
            PIECE_J_270:  pattern = {4'b0000, 4'b0011, 4'b0010, 4'b0010};
            PIECE_L_0:    pattern = {4'b0000, 4'b0000, 4'b0111, 4'b0100};
            PIECE_L_90:   pattern = {4'b0000, 4'b0011, 4'b0001, 4'b0001};
            PIECE_L_180:  pattern = {4'b0000, 4'b0000, 4'b0001, 4'b0111};
            PIECE_L_270:  pattern = {4'b0000, 4'b0010, 4'b0010, 4'b0011};
            PIECE_T_0:    pattern = {4'b0000, 4'b0000, 4'b0111, 4'b0010};
            PIECE_T_90:   pattern = {4'b0000, 4'b0001, 4'b0011, 4'b0001};
            PIECE_T_180:  pattern = {4'b0000, 4'b0000, 4'b0010, 4'b0111};
            PIECE_T_270:  pattern = {4'b0000, 4'b0010, 4'b0011, 4'b0010};
            default:      pattern = '0;
        endcase
    end

    // ==================================================
    // Falling mask and collision flags
    // ==================================================

    always_comb begin
        row_idx_t abs_row;
        col_idx_t abs_col;
        abs_row       = '0;
        abs_col       = '0;
        falling_o     = '0;
        coll_bottom_o = 1'b0;
        coll_left_o   = 1'b0;
        coll_right_o  = 1'b0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                abs_row = row_q + row_idx_t'(r);
                abs_col = col_q + col_idx_t'(c);
                if (pattern[r][c]) begin
                    // Cells past the edge are not drawn
                    if (abs_row < BOARD_ROWS && abs_col < BOARD_COLS) begin
                        falling_o[abs_row][abs_col] = 1'b1;
                    end
                    // Floor, or a stored cell right below
                    if (abs_row >= BOARD_ROWS - 1) begin
                        coll_bottom_o = 1'b1;
                    end else if (abs_col < BOARD_COLS && stored_i[abs_row + 5'd1][abs_col]) begin
                        coll_bottom_o = 1'b1;
                    end
                    // Left wall or stored neighbour
                    if (abs_col == 4'd0) begin
                        coll_left_o = 1'b1;
                    end else if (abs_row < BOARD_ROWS && abs_col <= BOARD_COLS &&
                                 stored_i[abs_row][abs_col - 4'd1]) begin
                        coll_left_o = 1'b1;
                    end
                    // Right wall or stored neighbour
                    if (abs_col >= BOARD_COLS - 1) begin
                        coll_right_o = 1'b1;
                    end else if (abs_row < BOARD_ROWS && stored_i[abs_row][abs_col + 4'd1]) begin
                        coll_right_o = 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* hdl/tetris_line_clear.sv */
`timescale 1ns/1ps

module tetris_line_clear (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start_i,
    input  tetris_board_pkg::board_t board_i,
    output tetris_board_pkg::board_t board_o,
    output logic                     done_o,
    output tetris_board_pkg::score_t score_o
);

    import tetris_board_pkg::*;

    // Working copy and scan pointer
    board_t   board_q;
    row_idx_t row_q;
    logic     busy_q;
    logic     done_q;
    score_t   score_q;
    logic     row_full;

    assign row_full = &board_q[row_q];

    assign board_o = board_q;
    assign done_o  = done_q;
    assign score_o = score_q;

    // ==================================================
    // Scan control, bottom row first
    // ==================================================

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            row_q   <= '0;
            score_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                row_q  <= row_idx_t'(BOARD_ROWS - 1);
            end else if (busy_q) begin
                if (row_full) begin
                    // Same row is looked at again after the shift
                    score_q <= score_q + 8'd1;
                end else if (row_q == '0) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    row_q <= row_q - 5'd1;
                end
            end
        end
    end

    // Board copy, full row drops out and everything above slides down
    always_ff @(posedge clk) begin
        if (start_i) begin
            board_q <= board_i;
        end else if (busy_q && row_full) begin
            for (int r = BOARD_ROWS - 1; r > 0; r--) begin
                if (row_idx_t'(r) <= row_q) begin
                    board_q[r] <= board_q[r-1];
                end
            end
            board_q[0] <= '0;
        end
    end

endmodule

/* hdl/tetris_game_ctrl.sv */
`timescale 1ns/1ps

module tetris_game_ctrl (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start_i,
    input  logic                          drop_i,
    input  logic                          rot_cw_i,
    input  logic                          rot_ccw_i,
    input  tetris_board_pkg::board_t      falling_i,
    input  tetris_piece_pkg::piece_code_t piece_code_i,
    input  logic                          coll_bottom_i,
    input  tetris_board_pkg::board_t      clear_board_i,
    input  logic                          clear_done_i,
    output tetris_board_pkg::game_state_t state_o,
    output logic                          clear_start_o,
    output tetris_board_pkg::board_t      stored_o,
    output tetris_board_pkg::board_t      display_o,
    output logic                          gameover_o
);

    import tetris_board_pkg::*;
    import tetris_piece_pkg::*;

    game_state_t state_q;
    game_state_t state_d;
    board_t      stored_q;
    board_t      lock_board;
    logic        lock_armed_q;
    logic        piece_live;

    // Stored cells with the falling piece merged in
    assign lock_board = stored_q | falling_i;

    // ==================================================
    // State register and lock delay
    // ==================================================

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state_q      <= INIT;
            lock_armed_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // First resting drop tick arms, leaving the ledge disarms
            if (state_q == FALLING) begin
                if (!coll_bottom_i) begin
                    lock_armed_q <= 1'b0;
                end else if (drop_i) begin
                    lock_armed_q <= 1'b1;
                end
            end else if (state_q != ROTATE) begin
                lock_armed_q <= 1'b0;
            end
        end
    end

    // Stored board, takes the piece in STUCK and the cleared board at the end of EVAL
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            stored_q <= '0;
        end else if (state_q == STUCK) begin
            stored_q <= lock_board;
        end else if (state_q == EVAL && clear_done_i) begin
            stored_q <= clear_board_i;
        end
    end

    // ==================================================
    // Next state
    // ==================================================

    always_comb begin
        state_d = state_q;
        case (state_q)
            INIT:     if (start_i) state_d = SPAWN;
            SPAWN:    state_d = FALLING;
            FALLING: begin
                // Lock beats rotate when both arrive together
                if (drop_i && coll_bottom_i && lock_armed_q) begin
                    state_d = STUCK;
                end else if ((rot_cw_i || rot_ccw_i) && piece_code_i != PIECE_O) begin
                    state_d = ROTATE;
                end
            end
            ROTATE:   state_d = FALLING;
            STUCK:    state_d = (|lock_board[0]) ? GAMEOVER : LANDED;
            LANDED:   state_d = EVAL;
            EVAL:     if (clear_done_i) state_d = SPAWN;
            GAMEOVER: state_d = GAMEOVER;
            default:  state_d = INIT;
        endcase
    end

    // Piece drawn only while it is on the board
    assign piece_live = state_q inside {FALLING, ROTATE, STUCK};

    assign display_o     = piece_live ? lock_board : stored_q;
    assign state_o       = state_q;
    assign stored_o      = stored_q;
    assign clear_start_o = (state_q == LANDED);
    assign gameover_o    = (state_q == GAMEOVER);

endmodule

/* hdl/tetris_top.sv */
`timescale 1ns/1ps

module tetris_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         left_i,
    input  logic                         right_i,
    input  logic                         rot_cw_i,
    input  logic                         rot_ccw_i,
    input  logic                         drop_tick_i,
    input  logic                         start_i,
    input  tetris_piece_pkg::piece_sel_t piece_sel_i,
    output tetris_board_pkg::board_t     display_o,
    output tetris_board_pkg::score_t     score_o,
    output logic                         gameover_o
);

    import tetris_board_pkg::*;
    import tetris_piece_pkg::*;

    // Strobes from the input side
    logic left_s;
    logic right_s;
    logic rot_cw_s;
    logic rot_ccw_s;
    logic drop_s;

    // Controller, engine and line-clear links
    game_state_t state;
    board_t      stored;
    board_t      falling;
    board_t      clear_board;
    piece_code_t piece_code;
    logic        coll_bottom;
    logic        clear_start;
    logic        clear_done;

    // ==================================================
    // Input side
    // ==================================================

    tetris_input_sync i_input_sync (
        .clk         (clk),
        .reset       (reset),
        .left_i      (left_i),
        .right_i     (right_i),
        .rot_cw_i    (rot_cw_i),
        .rot_ccw_i   (rot_ccw_i),
        .drop_tick_i (drop_tick_i),
        .left_o      (left_s),
        .right_o     (right_s),
        .rot_cw_o    (rot_cw_s),
        .rot_ccw_o   (rot_ccw_s),
        .drop_o      (drop_s)
    );

    // ==================================================
    // Processing part
    // ==================================================

    tetris_game_ctrl i_game_ctrl (
        .clk           (clk),
        .reset         (reset),
        .start_i       (start_i),
        .drop_i        (drop_s),
        .rot_cw_i      (rot_cw_s),
        .rot_ccw_i     (rot_ccw_s),
        .falling_i     (falling),
        .piece_code_i  (piece_code),
        .coll_bottom_i (coll_bottom),
        .clear_board_i (clear_board),
        .clear_done_i  (clear_done),
        .state_o       (state),
        .clear_start_o (clear_start),
        .stored_o      (stored),
        .display_o     (display_o),
        .gameover_o    (gameover_o)
    );

    // Side flags only steer the engine itself
    tetris_piece_engine i_piece_engine (
        .clk           (clk),
        .reset         (reset),
        .state_i       (state),
        .piece_sel_i   (piece_sel_i),
        .left_i        (left_s),
        .right_i       (right_s),
        .rot_cw_i      (rot_cw_s),
        .rot_ccw_i     (rot_ccw_s),
        .drop_i        (drop_s),
        .stored_i      (stored),
        .piece_code_o  (piece_code),
        .falling_o     (falling),
        .coll_bottom_o (coll_bottom),
        .coll_left_o   (),
        .coll_right_o  ()
    );

    tetris_line_clear i_line_clear (
        .clk     (clk),
        .reset   (reset),
        .start_i (clear_start),
        .board_i (stored),
        .board_o (clear_board),
        .done_o  (clear_done),
        .score_o (score_o)
    );

endmodule

/* dv/tetris_tb.sv */
`timescale 1ns/1ps

module tetris_tb;

    import tetris_board_pkg::*;
    import tetris_piece_pkg::*;

    // ==================================================
    // Timing and action codes
    // ==================================================

    localparam int SETTLE_LIMIT = 40;
    localparam int HOLD_CYCLES  = 4;

    localparam int ACT_NONE    = 0;
    localparam int ACT_START   = 1;
    localparam int ACT_LEFT    = 2;
    localparam int ACT_RIGHT   = 3;
    localparam int ACT_ROT_CW  = 4;
    localparam int ACT_ROT_CCW = 5;
    localparam int ACT_DROP    = 6;

    logic       clk;
    logic       reset;
    logic       left;
    logic       right;
    logic       rot_cw;
    logic       rot_ccw;
    logic       drop_tick;
    logic       start;
    piece_sel_t piece_sel;
    board_t     display;
    score_t     score;
    logic       gameover;

    // Result of the test in progress
    logic step_ok;

    // Stimulus and expectation table, one entry per test
    string      step_name[$];
    int         step_act[$];
    int         step_count[$];
    piece_sel_t step_sel[$];
    board_t     step_disp[$];
    score_t     step_score[$];
    logic       step_go[$];

    tetris_top i_tetris_top (
        .clk         (clk),
        .reset       (reset),
        .left_i      (left),
        .right_i     (right),
        .rot_cw_i    (rot_cw),
        .rot_ccw_i   (rot_ccw),
        .drop_tick_i (drop_tick),
        .start_i     (start),
        .piece_sel_i (piece_sel),
        .display_o   (display),
        .score_o     (score),
        .gameover_o  (gameover)
    );

    // 20 ns clock
    always #10 clk = ~clk;

    // ==================================================
    // Expected boards from the fixed patterns
    // ==================================================

    // Box corner at (row, col); only I and O shapes are needed
    function automatic board_t place_piece(board_t base, piece_code_t code, int row, int col);
        board_t b;
        b = base;
        for (int k = 0; k < 4; k++) begin
            if (code == PIECE_I_VERT) begin
                b[row_idx_t'(row + k)][col_idx_t'(col)] = 1'b1;
            end else if (code == PIECE_I_HORZ) begin
                b[row_idx_t'(row)][col_idx_t'(col + k)] = 1'b1;
            end else if (code == PIECE_O && k < 2) begin
                b[row_idx_t'(row + k)][col_idx_t'(col)]     = 1'b1;
                b[row_idx_t'(row + k)][col_idx_t'(col + 1)] = 1'b1;
            end
        end
        return b;
    endfunction

    task automatic add_step(input string name, input int act, input int count,
                            input piece_sel_t sel, input board_t disp,
                            input score_t sc, input logic go);
        step_name.push_back(name);
        step_act.push_back(act);
        step_count.push_back(count);
        step_sel.push_back(sel);
        step_disp.push_back(disp);
        step_score.push_back(sc);
        step_go.push_back(go);
    endtask

    task automatic build_table();
        board_t st;
        st = '0;
        add_step("reset_idle", ACT_NONE, 0, 3'd0, st, 8'd0, 1'b0);
        add_step("start_spawn", ACT_START, 1, 3'd0, place_piece(st, PIECE_I_VERT, 0, 3), 8'd0, 1'b0);
        add_step("drop_three", ACT_DROP, 3, 3'd0, place_piece(st, PIECE_I_VERT, 3, 3), 8'd0, 1'b0);
        add_step("left_one", ACT_LEFT, 1, 3'd0, place_piece(st, PIECE_I_VERT, 3, 2), 8'd0, 1'b0);
        add_step("left_to_wall", ACT_LEFT, 2, 3'd0, place_piece(st, PIECE_I_VERT, 3, 0), 8'd0, 1'b0);
        add_step("left_blocked", ACT_LEFT, 1, 3'd0, place_piece(st, PIECE_I_VERT, 3, 0), 8'd0, 1'b0);
        add_step("right_three", ACT_RIGHT, 3, 3'd0, place_piece(st, PIECE_I_VERT, 3, 3), 8'd0, 1'b0);
        add_step("rot_cw_horz", ACT_ROT_CW, 1, 3'd0, place_piece(st, PIECE_I_HORZ, 3, 3), 8'd0, 1'b0);
        add_step("rot_ccw_vert", ACT_ROT_CCW, 1, 3'd0, place_piece(st, PIECE_I_VERT, 3, 3), 8'd0,
                 1'b0);
        // First I goes flat into the bottom left corner
        add_step("a_rot_cw", ACT_ROT_CW, 1, 3'd0, place_piece(st, PIECE_I_HORZ, 3, 3), 8'd0, 1'b0);
        add_step("a_left_three", ACT_LEFT, 3, 3'd0, place_piece(st, PIECE_I_HORZ, 3, 0), 8'd0, 1'b0);
        add_step("a_to_floor", ACT_DROP, 16, 3'd0, place_piece(st, PIECE_I_HORZ, 19, 0), 8'd0, 1'b0);
        // Resting once only arms the lock
        add_step("a_rest", ACT_DROP, 1, 3'd0, place_piece(st, PIECE_I_HORZ, 19, 0), 8'd0, 1'b0);
        // Still live while armed, so it slides along the floor
        add_step("a_rest_right", ACT_RIGHT, 1, 3'd0, place_piece(st, PIECE_I_HORZ, 19, 1), 8'd0,
                 1'b0);
        add_step("a_rest_left", ACT_LEFT, 1, 3'd0, place_piece(st, PIECE_I_HORZ, 19, 0), 8'd0,
                 1'b0);
        st = place_piece(st, PIECE_I_HORZ, 19, 0);
        add_step("a_lock", ACT_DROP, 1, 3'd0, place_piece(st, PIECE_I_VERT, 0, 3), 8'd0, 1'b0);
        // Second I fills columns 4 to 7
        add_step("b_rot_cw", ACT_ROT_CW, 1, 3'd0, place_piece(st, PIECE_I_HORZ, 0, 3), 8'd0, 1'b0);
        add_step("b_right", ACT_RIGHT, 1, 3'd0, place_piece(st, PIECE_I_HORZ, 0, 4), 8'd0, 1'b0);
        add_step("b_to_floor", ACT_DROP, 19, 3'd0, place_piece(st, PIECE_I_HORZ, 19, 4), 8'd0, 1'b0);
        st = place_piece(st, PIECE_I_HORZ, 19, 4);
        add_step("b_rest_lock", ACT_DROP, 2, 3'd1, place_piece(st, PIECE_O, 0, 3), 8'd0, 1'b0);
        // O never turns
        add_step("o_rot_cw", ACT_ROT_CW, 1, 3'd1, place_piece(st, PIECE_O, 0, 3), 8'd0, 1'b0);
        add_step("o_rot_ccw", ACT_ROT_CCW, 1, 3'd1, place_piece(st, PIECE_O, 0, 3), 8'd0, 1'b0);
        add_step("o_right_five", ACT_RIGHT, 5, 3'd1, place_piece(st, PIECE_O, 0, 8), 8'd0, 1'b0);
        add_step("o_to_floor", ACT_DROP, 18, 3'd1, place_piece(st, PIECE_O, 18, 8), 8'd0, 1'b0);
        // Row 19 goes, upper half of the O slides into it
        st = '0;
        st[19] = 10'h300;
        add_step("o_lock_clear", ACT_DROP, 2, 3'd0, place_piece(st, PIECE_I_VERT, 0, 3), 8'd1, 1'b0);
        // Column 3 stack, four rows per piece
        st = place_piece(st, PIECE_I_VERT, 16, 3);
        add_step("stack_1", ACT_DROP, 18, 3'd0, place_piece(st, PIECE_I_VERT, 0, 3), 8'd1, 1'b0);
        st = place_piece(st, PIECE_I_VERT, 12, 3);
        add_step("stack_2", ACT_DROP, 14, 3'd0, place_piece(st, PIECE_I_VERT, 0, 3), 8'd1, 1'b0);
        st = place_piece(st, PIECE_I_VERT, 8, 3);
        add_step("stack_3", ACT_DROP, 10, 3'd0, place_piece(st, PIECE_I_VERT, 0, 3), 8'd1, 1'b0);
        st = place_piece(st, PIECE_I_VERT, 4, 3);
        add_step("stack_4", ACT_DROP, 6, 3'd0, place_piece(st, PIECE_I_VERT, 0, 3), 8'd1, 1'b0);
        // Last piece locks in row 0
        st = place_piece(st, PIECE_I_VERT, 0, 3);
        add_step("stack_over", ACT_DROP, 2, 3'd0, st, 8'd1, 1'b1);
        add_step("frozen_drop", ACT_DROP, 2, 3'd0, st, 8'd1, 1'b1);
        add_step("frozen_left", ACT_LEFT, 1, 3'd0, st, 8'd1, 1'b1);
    endtask

    // ==================================================
    // Drivers
    // ==================================================

    // Inputs change 2 ns after the rising edge
    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic set_button(input int act, input logic value);
        case (act)
            ACT_START:   start = value;
            ACT_LEFT:    left = value;
            ACT_RIGHT:   right = value;
            ACT_ROT_CW:  rot_cw = value;
            ACT_ROT_CCW: rot_ccw = value;
            ACT_DROP:    drop_tick = value;
            default: begin
            end
        endcase
    endtask

    // 4 cycles high, 4 low per press
    task automatic apply_action(input int act, input int count);
        for (int n = 0; n < count; n++) begin
            set_button(act, 1'b1);
            step_cycles(HOLD_CYCLES);
            set_button(act, 1'b0);
            step_cycles(HOLD_CYCLES);
        end
    endtask

    // Line clear can take 20+ cycles before the next spawn shows
    task automatic wait_for_result(input board_t exp_disp, input score_t exp_score,
                                   input logic exp_go, output logic reached);
        int n;
        reached = 1'b0;
        n = 0;
        while (!reached && n < SETTLE_LIMIT) begin
            if (display === exp_disp && score === exp_score && gameover === exp_go) begin
                reached = 1'b1;
            end else begin
                step_cycles(1);
                n++;
            end
        end
    endtask

    // ==================================================
    // Compare tasks
    // ==================================================

    task automatic compare_board(input string name, input board_t exp, input board_t act);
        if (act !== exp) begin
            $display("ERROR %s display: expected %h, actual %h", name, exp, act);
            step_ok = 1'b0;
        end
    endtask

    task automatic compare_score(input string name, input score_t exp, input score_t act);
        if (act !== exp) begin
            $display("ERROR %s score: expected %0d, actual %0d", name, exp, act);
            step_ok = 1'b0;
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s gameover: expected %b, actual %b", name, exp, act);
            step_ok = 1'b0;
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        int   failed;
        logic reached;
        failed    = 0;
        clk       = 1'b0;
        reset     = 1'b1;
        left      = 1'b0;
        right     = 1'b0;
        rot_cw    = 1'b0;
        rot_ccw   = 1'b0;
        drop_tick = 1'b0;
        start     = 1'b0;
        piece_sel = '0;
        step_ok   = 1'b1;
        build_table();
        step_cycles(5);
        reset = 1'b0;
        for (int i = 0; i < step_name.size(); i++) begin
            step_ok   = 1'b1;
            piece_sel = step_sel[i];
            apply_action(step_act[i], step_count[i]);
            wait_for_result(step_disp[i], step_score[i], step_go[i], reached);
            if (!reached) begin
                $display("%s: outputs did not settle to the expected values within %0d cycles",
                         step_name[i], SETTLE_LIMIT);
                step_ok = 1'b0;
            end
            compare_board(step_name[i], step_disp[i], display);
            compare_score(step_name[i], step_score[i], score);
            compare_flag(step_name[i], step_go[i], gameover);
            $display("test %0d %s: %s", i, step_name[i], step_ok ? "ok" : "failed");
            if (!step_ok) begin
                failed++;
            end
        end
        $display("%0d tests, %0d passed, %0d failed", step_name.size(),
                 step_name.size() - failed, failed);
        if (failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
hdl/tetris_board_pkg.sv
hdl/tetris_piece_pkg.sv
hdl/tetris_input_sync.sv
hdl/tetris_piece_engine.sv
hdl/tetris_line_clear.sv
hdl/tetris_game_ctrl.sv
hdl/tetris_top.sv
dv/tetris_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module tetris_tb -f vlog.f -o tetris_sim

output=$(./obj_dir/tetris_sim)
echo "$output"

if echo "$output" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
